//--- execPkg.sv
package execPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // operand source select from the hazard unit, value 3 is reserved
    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdMem = 2'd1,
        fwdWb  = 2'd2
    } forwardT;

    typedef struct packed {
        logic [5:0] op;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  op;
        regAddrT     rs;
        regAddrT     rt;
        logic [15:0] imm;
    } iTypeT;

    // one instruction word, two views
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrU;

    typedef enum logic [4:0] {
        exAdd, exAddu, exSub, exSubu, exAnd, exOr, exXor, exNor,
        exSlt, exSltu, exSll, exSrl, exSra, exLui, exLink,
        exMult, exMultu, exDiv, exDivu, exMfhi, exMflo, exNone
    } execOpT;

    // primary opcodes
    localparam logic [5:0] opcSpecial = 6'h00;
    localparam logic [5:0] opcJal     = 6'h03;
    localparam logic [5:0] opcAddi    = 6'h08;
    localparam logic [5:0] opcAddiu   = 6'h09;
    localparam logic [5:0] opcSlti    = 6'h0a;
    localparam logic [5:0] opcAndi    = 6'h0c;
    localparam logic [5:0] opcOri     = 6'h0d;
    localparam logic [5:0] opcXori    = 6'h0e;
    localparam logic [5:0] opcLui     = 6'h0f;

    // funct field of special opcode
    localparam logic [5:0] fnSll   = 6'h00;
    localparam logic [5:0] fnSrl   = 6'h02;
    localparam logic [5:0] fnSra   = 6'h03;
    localparam logic [5:0] fnMfhi  = 6'h10;
    localparam logic [5:0] fnMflo  = 6'h12;
    localparam logic [5:0] fnMult  = 6'h18;
    localparam logic [5:0] fnMultu = 6'h19;
    localparam logic [5:0] fnDiv   = 6'h1a;
    localparam logic [5:0] fnDivu  = 6'h1b;
    localparam logic [5:0] fnAdd   = 6'h20;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSub   = 6'h22;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnXor   = 6'h26;
    localparam logic [5:0] fnNor   = 6'h27;
    localparam logic [5:0] fnSlt   = 6'h2a;
    localparam logic [5:0] fnSltu  = 6'h2b;

    localparam regAddrT linkReg = 5'd31;

endpackage

//--- operandBus.sv
interface operandBus import execPkg::*; ();

    logic       issue;
    execOpT     op;
    wordT       srcA;
    wordT       srcB;
    wordT       operandB;
    logic [4:0] shamt;
    regAddrT    destReg;
    wordT       pcPlus4;

    // decode side
    modport route (
        output issue, op, srcA, srcB, operandB, shamt, destReg, pcPlus4
    );

    // alu and multiply/divide paths
    modport exec (
        input issue, op, srcA, srcB, operandB, shamt, pcPlus4
    );

    // result register only needs control and destination
    modport merge (
        input issue, op, destReg
    );

endinterface

//--- operandRoute.sv
module operandRoute import execPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     issueValid,
    input  instrU    instr,
    input  wordT     regA,
    input  wordT     regB,
    input  wordT     pcPlus4,
    input  forwardT  forwardA,
    input  forwardT  forwardB,
    input  wordT     memValue,
    input  wordT     wbValue,
    operandBus.route bus
);
    execOpT  op;
    logic    useImm;
    logic    signExt;
    regAddrT destReg;
    wordT    srcA;
    wordT    srcB;
    wordT    immExt;

    function automatic wordT pickSource(forwardT sel, wordT regVal, wordT memVal,
                                        wordT wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = pickSource(forwardA, regA, memValue, wbValue);
    assign srcB = pickSource(forwardB, regB, memValue, wbValue);

    always_comb begin
        op      = exNone;
        useImm  = 1'b0;
        signExt = 1'b1;
        destReg = instr.r.rd;
        if (instr.r.op == opcSpecial) begin
            case (instr.r.funct)
                fnAdd:   op = exAdd;
                fnAddu:  op = exAddu;
                fnSub:   op = exSub;
                fnSubu:  op = exSubu;
                fnAnd:   op = exAnd;
                fnOr:    op = exOr;
                fnXor:   op = exXor;
                fnNor:   op = exNor;
                fnSlt:   op = exSlt;
                fnSltu:  op = exSltu;
                fnSll:   op = exSll;
                fnSrl:   op = exSrl;
                fnSra:   op = exSra;
                fnMult:  op = exMult;
                fnMultu: op = exMultu;
                fnDiv:   op = exDiv;
                fnDivu:  op = exDivu;
                fnMfhi:  op = exMfhi;
                fnMflo:  op = exMflo;
                default: op = exNone;
            endcase
        end else begin
            // i-type view, result goes to rt
            useImm  = 1'b1;
            destReg = instr.i.rt;
            case (instr.i.op)
                opcAddi:  op = exAdd;
                opcAddiu: op = exAddu;
                opcSlti:  op = exSlt;
                opcLui:   op = exLui;
                opcAndi: begin
                    op      = exAnd;
                    signExt = 1'b0;
                end
                opcOri: begin
                    op      = exOr;
                    signExt = 1'b0;
                end
                opcXori: begin
                    op      = exXor;
                    signExt = 1'b0;
                end
                opcJal: begin
                    op      = exLink;
                    destReg = linkReg;
                end
                default: op = exNone;
            endcase
        end
    end

    assign immExt = signExt ? {{16{instr.i.imm[15]}}, instr.i.imm} : {16'h0000, instr.i.imm};

    // unsupported encodings never issue
    assign bus.issue    = issueValid && (op != exNone);
    assign bus.op       = op;
    assign bus.srcA     = srcA;
    assign bus.srcB     = srcB;
    assign bus.operandB = useImm ? immExt : srcB;
    assign bus.shamt    = instr.r.shamt;
    assign bus.destReg  = destReg;
    assign bus.pcPlus4  = pcPlus4;

    // hazard unit must never hand over the reserved select
    assert property (@(posedge clk) disable iff (!rstN)
        (forwardA != 2'd3) && (forwardB != 2'd3));

endmodule

//--- aluPath.sv
module aluPath import execPkg::*; (
    operandBus.exec bus,
    output wordT    aluResult,
    output logic    overflow
);
    wordT a;
    wordT b;
    wordT sum;
    wordT diff;
    logic addOvf;
    logic subOvf;

    assign a    = bus.srcA;
    assign b    = bus.operandB;
    assign sum  = a + b;
    assign diff = a - b;

    // signed overflow, sign of result disagrees with operands
    assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        aluResult = '0;
        overflow  = 1'b0;
        case (bus.op)
            exAdd: begin
                aluResult = sum;
                overflow  = addOvf;
            end
            exSub: begin
                aluResult = diff;
                overflow  = subOvf;
            end
            exAddu: aluResult = sum;
            exSubu: aluResult = diff;
            exAnd:  aluResult = a & b;
            exOr:   aluResult = a | b;
            exXor:  aluResult = a ^ b;
            exNor:  aluResult = ~(a | b);
            exSlt:  aluResult = {31'd0, $signed(a) < $signed(b)};
            exSltu: aluResult = {31'd0, a < b};
            // shifts work on rt by the shamt field
            exSll:  aluResult = bus.srcB << bus.shamt;
            exSrl:  aluResult = bus.srcB >> bus.shamt;
            exSra:  aluResult = wordT'($signed(bus.srcB) >>> bus.shamt);
            exLui:  aluResult = {b[15:0], 16'h0000};
            // return address skips the delay slot
            exLink: aluResult = bus.pcPlus4 + 32'd4;
            default: begin
                aluResult = '0;
                overflow  = 1'b0;
            end
        endcase
    end

endmodule

//--- mulDivUnit.sv
module mulDivUnit import execPkg::*; #(
    parameter int mulDivSteps = 32
) (
    input  logic    clk,
    input  logic    rstN,
    operandBus.exec bus,
    output logic    busy,
    output logic    done,
    output wordT    hiOut,
    output wordT    loOut
);
    localparam int cntW = $clog2(mulDivSteps + 1);

    logic [cntW-1:0] count;
    logic            startMd;
    logic            signedOp;
    logic            divOp;
    logic            isDiv;
    logic            negA;
    logic            negB;
    wordT            magA;
    wordT            magB;
    wordT            accHi;
    wordT            accLo;
    wordT            stepOperand;
    wordT            nextHi;
    wordT            nextLo;
    logic [32:0]     mulSum;
    logic [32:0]     remShift;
    logic [32:0]     trial;
    logic [63:0]     product;

    assign startMd  = bus.issue && (bus.op inside {exMult, exMultu, exDiv, exDivu});
    assign signedOp = bus.op inside {exMult, exDiv};
    assign divOp    = bus.op inside {exDiv, exDivu};
    assign magA     = (signedOp && bus.srcA[31]) ? -bus.srcA : bus.srcA;
    assign magB     = (signedOp && bus.srcB[31]) ? -bus.srcB : bus.srcB;

    // shift-add step, multiplier sits in accLo
    assign mulSum = {1'b0, accHi} + (accLo[0] ? {1'b0, stepOperand} : 33'd0);

    // restoring step, quotient bits shift into accLo
    assign remShift = {accHi, accLo[31]};
    assign trial    = remShift - {1'b0, stepOperand};

    always_comb begin
        if (isDiv) begin
            if (!trial[32]) begin
                nextHi = trial[31:0];
                nextLo = {accLo[30:0], 1'b1};
            end else begin
                nextHi = remShift[31:0];
                nextLo = {accLo[30:0], 1'b0};
            end
        end else begin
            nextHi = mulSum[32:1];
            nextLo = {mulSum[0], accLo[31:1]};
        end
    end

    // signs applied to the final step, valid while done is high
    assign product = {nextHi, nextLo};

    always_comb begin
        hiOut = nextHi;
        loOut = nextLo;
        if (isDiv) begin
            loOut = (negA ^ negB) ? -nextLo : nextLo;
            hiOut = negA ? -nextHi : nextHi;
        end else if (negA ^ negB) begin
            {hiOut, loOut} = -product;
        end
    end

    assign done = busy && (count == cntW'(1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (startMd) begin
            busy  <= 1'b1;
            count <= cntW'(mulDivSteps);
        end else if (busy) begin
            count <= count - cntW'(1);
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startMd) begin
            isDiv       <= divOp;
            negA        <= signedOp && bus.srcA[31];
            negB        <= signedOp && bus.srcB[31];
            accHi       <= '0;
            accLo       <= divOp ? magA : magB;
            stepOperand <= divOp ? magB : magA;
        end else if (busy) begin
            accHi <= nextHi;
            accLo <= nextLo;
        end
    end

    // stage stalls upstream, nothing may issue while iterating
    assert property (@(posedge clk) disable iff (!rstN) busy |-> !bus.issue);
    assert property (@(posedge clk) disable iff (!rstN) done |=> !busy);

endmodule

//--- resultMerge.sv
module resultMerge import execPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    operandBus.merge bus,
    input  wordT     aluResult,
    input  logic     overflow,
    input  logic     mdDone,
    input  wordT     mdHi,
    input  wordT     mdLo,
    output logic     resultValid,
    output wordT     result,
    output regAddrT  writeReg,
    output logic     ovfFlag,
    output wordT     hi,
    output wordT     lo
);
    logic aluIssue;
    wordT nextResult;

    // multiply and divide only update hi/lo
    assign aluIssue = bus.issue && !(bus.op inside {exMult, exMultu, exDiv, exDivu});

    always_comb begin
        case (bus.op)
            exMfhi:  nextResult = hi;
            exMflo:  nextResult = lo;
            default: nextResult = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            hi          <= '0;
            lo          <= '0;
        end else begin
            resultValid <= aluIssue;
            if (mdDone) begin
                hi <= mdHi;
                lo <= mdLo;
            end
        end
    end

    // execute to memory payload
    always_ff @(posedge clk) begin
        if (aluIssue) begin
            result   <= nextResult;
            writeReg <= bus.destReg;
            ovfFlag  <= overflow;
        end
    end

endmodule

//--- execUnit.sv
module execUnit import execPkg::*; #(
    parameter int mulDivSteps = 32
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        issueValid,
    input  logic [31:0] instr,
    input  wordT        regA,
    input  wordT        regB,
    input  wordT        pcPlus4,
    input  forwardT     forwardA,
    input  forwardT     forwardB,
    input  wordT        memValue,
    input  wordT        wbValue,
    output logic        resultValid,
    output wordT        result,
    output regAddrT     writeReg,
    output logic        overflow,
    output logic        busy,
    output wordT        hi,
    output wordT        lo
);
    wordT aluResult;
    logic aluOverflow;
    logic mdDone;
    wordT mdHi;
    wordT mdLo;

    operandBus opBus ();

    operandRoute u_operandRoute (
        .clk, .rstN, .issueValid, .instr, .regA, .regB, .pcPlus4,
        .forwardA, .forwardB, .memValue, .wbValue, .bus(opBus.route)
    );

    aluPath u_aluPath (.bus(opBus.exec), .aluResult, .overflow(aluOverflow));

    mulDivUnit #(.mulDivSteps(mulDivSteps)) u_mulDivUnit (
        .clk, .rstN, .bus(opBus.exec), .busy, .done(mdDone), .hiOut(mdHi), .loOut(mdLo)
    );

    resultMerge u_resultMerge (
        .clk, .rstN, .bus(opBus.merge), .aluResult, .overflow(aluOverflow),
        .mdDone, .mdHi, .mdLo, .resultValid, .result, .writeReg,
        .ovfFlag(overflow), .hi, .lo
    );

endmodule

//--- execChecker.sv
module execChecker import execPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    expIssue,
    input  logic    expMd,
    input  wordT    expResult,
    input  regAddrT expReg,
    input  logic    expOvf,
    input  wordT    expHi,
    input  wordT    expLo,
    input  logic    resultValid,
    input  wordT    result,
    input  regAddrT writeReg,
    input  logic    overflow,
    input  logic    busy,
    input  wordT    hi,
    input  wordT    lo,
    output int      errorCount,
    output int      checkCount
);
    timeunit 1ns;
    timeprecision 1ns;

    logic    pending;
    logic    mdPending;
    logic    busyLast;
    logic    afterReset;
    wordT    wantResult;
    regAddrT wantReg;
    logic    wantOvf;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    task automatic compareWord(string name, wordT got, wordT want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic protocolError(string what);
        errorCount++;
        $display("%s", what);
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            pending    <= 1'b0;
            mdPending  <= 1'b0;
            busyLast   <= 1'b0;
            afterReset <= 1'b1;
        end else begin
            // first cycle out of reset
            if (afterReset) begin
                compareWord("busy", wordT'(busy), 32'h0);
                compareWord("resultValid", wordT'(resultValid), 32'h0);
                compareWord("hi", hi, 32'h0);
                compareWord("lo", lo, 32'h0);
            end
            if (pending && !resultValid) begin
                protocolError("resultValid did not rise one cycle after an ALU issue");
            end else if (pending) begin
                compareWord("result", result, wantResult);
                compareWord("writeReg", wordT'(writeReg), wordT'(wantReg));
                compareWord("overflow", wordT'(overflow), wordT'(wantOvf));
            end else if (resultValid) begin
                protocolError("resultValid rose with no ALU issue pending");
            end
            if (mdPending && !busy) begin
                protocolError("busy did not rise after a multiply/divide issue");
            end
            // hi and lo settle as busy drops
            if (busyLast && !busy) begin
                compareWord("hi", hi, expHi);
                compareWord("lo", lo, expLo);
            end
            pending    <= expIssue;
            mdPending  <= expMd;
            wantResult <= expResult;
            wantReg    <= expReg;
            wantOvf    <= expOvf;
            busyLast   <= busy;
            afterReset <= 1'b0;
        end
    end

endmodule

//--- tbExecUnit.sv
module tbExecUnit import execPkg::*; ();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int steps   = 32;
    localparam int numAlu  = 200;
    localparam int numFwd  = 60;
    localparam int numJal  = 4;
    localparam int numMd   = 40;
    localparam int numMove = 8;
    // one cycle per ALU op doubled, about 40 per multiply/divide
    localparam int cycleLimit = 40 + 2 * (numAlu + numFwd + numJal + 2 * numMove)
                                + 40 * (numMd + numMove);

    localparam logic [5:0] rCodes [13] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr,
        fnXor, fnNor, fnSlt, fnSltu, fnSll, fnSrl, fnSra};
    localparam logic [5:0] iCodes [7] = '{opcAddi, opcAddiu, opcSlti, opcAndi, opcOri,
        opcXori, opcLui};
    localparam logic [5:0] mdCodes [4] = '{fnMult, fnMultu, fnDiv, fnDivu};

    typedef struct packed {
        logic    toResult;
        logic    toHiLo;
        wordT    value;
        logic    ovf;
        regAddrT dest;
        wordT    newHi;
        wordT    newLo;
    } expectT;

    logic        clk;
    logic        rstN;
    logic        issueValid;
    logic [31:0] instr;
    wordT        regA;
    wordT        regB;
    wordT        pcPlus4;
    forwardT     forwardA;
    forwardT     forwardB;
    wordT        memValue;
    wordT        wbValue;
    logic        resultValid;
    wordT        result;
    regAddrT     writeReg;
    logic        overflow;
    logic        busy;
    wordT        hi;
    wordT        lo;

    logic    expIssue;
    logic    expMd;
    wordT    expResult;
    regAddrT expReg;
    logic    expOvf;
    wordT    expHi;
    wordT    expLo;
    wordT    modelHi;
    wordT    modelLo;
    int      errorCount;
    int      checkCount;
    int      errsBefore = 0;
    int      testCount = 0;
    int      cycles = 0;

    execUnit #(.mulDivSteps(steps)) u_execUnit (
        .clk, .rstN, .issueValid, .instr, .regA, .regB, .pcPlus4, .forwardA, .forwardB,
        .memValue, .wbValue, .resultValid, .result, .writeReg, .overflow, .busy, .hi, .lo
    );

    execChecker u_execChecker (
        .clk, .rstN, .expIssue, .expMd, .expResult, .expReg, .expOvf, .expHi, .expLo,
        .resultValid, .result, .writeReg, .overflow, .busy, .hi, .lo,
        .errorCount, .checkCount
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // expected outcome of one instruction from the ISA rules
    function automatic expectT refExec(logic [31:0] ins, wordT a, wordT rb, wordT pc,
                                       wordT curHi, wordT curLo);
        expectT      e;
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  sh;
        wordT        b;
        wordT        magA;
        wordT        magB;
        wordT        q;
        wordT        r;
        logic [32:0] wide;
        logic [63:0] w64;
        logic        negA;
        logic        negB;
        opc = ins[31:26];
        fn  = ins[5:0];
        sh  = ins[10:6];
        e = '0;
        e.newHi    = curHi;
        e.newLo    = curLo;
        e.toResult = 1'b1;
        e.dest     = (opc == opcSpecial) ? ins[15:11] : ins[20:16];
        b = (opc == opcSpecial) ? rb : {{16{ins[15]}}, ins[15:0]};
        if (opc inside {opcAndi, opcOri, opcXori}) begin
            b = {16'h0000, ins[15:0]};
        end
        if (opc == opcSpecial) begin
            case (fn)
                fnAdd, fnAddu: e.value = a + b;
                fnSub, fnSubu: e.value = a - b;
                fnAnd:   e.value = a & b;
                fnOr:    e.value = a | b;
                fnXor:   e.value = a ^ b;
                fnNor:   e.value = ~(a | b);
                fnSlt:   e.value = {31'd0, $signed(a) < $signed(b)};
                fnSltu:  e.value = {31'd0, a < b};
                fnSll:   e.value = rb << sh;
                fnSrl:   e.value = rb >> sh;
                fnMfhi:  e.value = curHi;
                fnMflo:  e.value = curLo;
                fnSra: begin
                    w64     = {{32{rb[31]}}, rb} >> sh;
                    e.value = w64[31:0];
                end
                default: e.value = '0;
            endcase
            if (fn == fnAdd) begin
                wide  = {a[31], a} + {b[31], b};
                e.ovf = wide[32] != wide[31];
            end
            if (fn == fnSub) begin
                wide  = {a[31], a} - {b[31], b};
                e.ovf = wide[32] != wide[31];
            end
            if (fn inside {fnMult, fnMultu, fnDiv, fnDivu}) begin
                e.toResult = 1'b0;
                e.toHiLo   = 1'b1;
                negA = (fn == fnMult || fn == fnDiv) && a[31];
                negB = (fn == fnMult || fn == fnDiv) && rb[31];
                if (fn == fnMult || fn == fnMultu) begin
                    w64 = (fn == fnMult) ? {{32{a[31]}}, a} * {{32{rb[31]}}, rb}
                                         : {32'h0, a} * {32'h0, rb};
                    e.newHi = w64[63:32];
                    e.newLo = w64[31:0];
                end else begin
                    magA = negA ? -a : a;
                    magB = negB ? -rb : rb;
                    // zero divisor gives all ones and the dividend back
                    q = (magB == 32'h0) ? 32'hffff_ffff : magA / magB;
                    r = (magB == 32'h0) ? magA : magA % magB;
                    e.newLo = (negA != negB) ? -q : q;
                    e.newHi = negA ? -r : r;
                end
            end
        end else begin
            case (opc)
                opcAddi, opcAddiu: e.value = a + b;
                opcSlti: e.value = {31'd0, $signed(a) < $signed(b)};
                opcAndi: e.value = a & b;
                opcOri:  e.value = a | b;
                opcXori: e.value = a ^ b;
                opcLui:  e.value = {ins[15:0], 16'h0000};
                opcJal: begin
                    e.value = pc + 32'd4;
                    e.dest  = 5'd31;
                end
                default: e.value = '0;
            endcase
            if (opc == opcAddi) begin
                wide  = {a[31], a} + {b[31], b};
                e.ovf = wide[32] != wide[31];
            end
        end
        return e;
    endfunction

    // sign boundaries come up often
    function automatic wordT pickOperand();
        logic [2:0] k;
        k = 3'($urandom_range(7));
        case (k)
            3'd0:    return 32'h7fff_ffff;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'h0000_0001;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] randomAluInstr();
        logic [3:0]  k;
        logic [2:0]  j;
        wordT        imm;
        imm = pickOperand();
        if ($urandom_range(1) == 0) begin
            k = 4'($urandom_range(12));
            return {opcSpecial, 5'($urandom), 5'($urandom), 5'($urandom), 5'($urandom),
                    rCodes[k]};
        end
        j = 3'($urandom_range(6));
        return {iCodes[j], 5'($urandom), 5'($urandom), imm[15:0]};
    endfunction

    function automatic forwardT randomSelect();
        logic [1:0] sel;
        sel = 2'($urandom_range(2));
        return forwardT'(sel);
    endfunction

    task automatic issueOp(logic [31:0] ins, wordT ra, wordT rb, forwardT fa, forwardT fb,
                           wordT mv, wordT wv, wordT pc);
        expectT e;
        wordT   a;
        wordT   b;
        a = (fa == fwdMem) ? mv : (fa == fwdWb) ? wv : ra;
        b = (fb == fwdMem) ? mv : (fb == fwdWb) ? wv : rb;
        e = refExec(ins, a, b, pc, modelHi, modelLo);
        issueValid = 1'b1;
        instr      = ins;
        regA       = ra;
        regB       = rb;
        forwardA   = fa;
        forwardB   = fb;
        memValue   = mv;
        wbValue    = wv;
        pcPlus4    = pc;
        expIssue   = e.toResult;
        expMd      = e.toHiLo;
        expResult  = e.value;
        expReg     = e.dest;
        expOvf     = e.ovf;
        if (e.toHiLo) begin
            modelHi = e.newHi;
            modelLo = e.newLo;
            expHi   = e.newHi;
            expLo   = e.newLo;
        end
        @(negedge clk);
        issueValid = 1'b0;
        expIssue   = 1'b0;
        expMd      = 1'b0;
        if (e.toHiLo) begin
            while (busy) @(negedge clk);
            // let the checker see hi and lo before the next issue
            @(negedge clk);
        end
    endtask

    task automatic mulDivOp(int i);
        logic [1:0] k;
        wordT       rb;
        k  = 2'($urandom_range(3));
        rb = ($urandom_range(5) == 0) ? 32'h0 : pickOperand();
        if (i < 2) begin
            k  = (i == 0) ? 2'd2 : 2'd3;
            rb = 32'h0;
        end
        issueOp({opcSpecial, 5'($urandom), 5'($urandom), 10'd0, mdCodes[k]}, pickOperand(),
                rb, fwdReg, fwdReg, 32'h0, 32'h0, 32'h0);
    endtask

    task automatic finishTest(string name);
        @(negedge clk);
        testCount++;
        $display("test %-8s done, %0d errors", name, errorCount - errsBefore);
        errsBefore = errorCount;
    endtask

    initial begin
        logic [31:0] ins;
        wordT        ra;
        wordT        rb;
        void'($urandom(32'h0784_84e7));
        rstN       = 1'b0;
        issueValid = 1'b0;
        instr      = '0;
        regA       = '0;
        regB       = '0;
        pcPlus4    = '0;
        forwardA   = fwdReg;
        forwardB   = fwdReg;
        memValue   = '0;
        wbValue    = '0;
        expIssue   = 1'b0;
        expMd      = 1'b0;
        expResult  = '0;
        expReg     = '0;
        expOvf     = 1'b0;
        expHi      = '0;
        expLo      = '0;
        modelHi    = '0;
        modelLo    = '0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        repeat (2) @(negedge clk);
        finishTest("reset");

        for (int i = 0; i < numAlu; i++) begin
            ins = randomAluInstr();
            ra  = pickOperand();
            rb  = pickOperand();
            issueOp(ins, ra, rb, fwdReg, fwdReg, 32'h0, 32'h0, 32'h0);
        end
        finishTest("alu");

        // memory and writeback values differ from the register values
        for (int i = 0; i < numFwd; i++) begin
            ins = randomAluInstr();
            issueOp(ins, $urandom, $urandom, randomSelect(), randomSelect(), $urandom,
                    $urandom, 32'h0);
        end
        finishTest("forward");

        for (int i = 0; i < numJal; i++) begin
            ins = {opcJal, 26'($urandom)};
            issueOp(ins, $urandom, $urandom, fwdReg, fwdReg, 32'h0, 32'h0,
                    $urandom & 32'hffff_fffc);
        end
        finishTest("jal");

        for (int i = 0; i < numMd; i++) begin
            mulDivOp(i);
        end
        finishTest("muldiv");

        for (int i = 0; i < numMove; i++) begin
            mulDivOp(i + 2);
            issueOp({opcSpecial, 10'd0, 5'($urandom), 5'd0, fnMfhi}, $urandom, $urandom,
                    fwdReg, fwdReg, 32'h0, 32'h0, 32'h0);
            issueOp({opcSpecial, 10'd0, 5'($urandom), 5'd0, fnMflo}, $urandom, $urandom,
                    fwdReg, fwdReg, 32'h0, 32'h0, 32'h0);
        end
        finishTest("move");

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- sources.f
execPkg.sv
operandBus.sv
operandRoute.sv
aluPath.sv
mulDivUnit.sv
resultMerge.sv
execUnit.sv
execChecker.sv
tbExecUnit.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbExecUnit
FILELIST = sources.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
